//--- hdl/vdec_pkg.sv
// vdec_pkg: widths, encodings and record types shared by the
// two-lane vector decode stage
`default_nettype none

package vdec_pkg;

  // element offsets cover a 256-element register group
  localparam int unsigned OFFSET_W = 8;

  typedef logic [31:0]         instr_t;
  typedef logic [4:0]          vreg_idx_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [31:0]         xlen_t;

  // selected element width, same encoding as vtype.vsew
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // operations this stage understands
  typedef enum logic [2:0] {
    OP_ADD       = 3'd0,
    OP_WADD      = 3'd1,
    OP_NSRL      = 3'd2,
    OP_SLIDE1UP  = 3'd3,
    OP_SLIDEUP_X = 3'd4,
    OP_GATHER_I  = 3'd5,
    OP_ILLEGAL   = 3'd6
  } valu_op_t;

  // where the destination element offsets come from
  typedef enum logic [2:0] {
    VD_SRC_NORMAL       = 3'd0,
    VD_SRC_IDX_PLUS_1   = 3'd1,
    VD_SRC_IDX_PLUS_RS1 = 3'd2
  } vd_src_t;

  // where the vs2 element offsets come from
  typedef enum logic [1:0] {
    VS2_SRC_NORMAL = 2'd0,
    VS2_SRC_UIMM   = 2'd1
  } vs2_src_t;

  // decoded control fields of one instruction word
  typedef struct packed {
    valu_op_t  op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    logic [4:0] imm5;
    // vm = 1 means unmasked
    logic      vm;
    logic      vd_widen;
    logic      vd_narrow;
    vd_src_t   vd_src;
    vs2_src_t  vs2_src;
    logic      legal;
  } dec_ctrl_t;

  // element offsets for lane 0 and lane 1
  typedef struct packed {
    offset_t offset0;
    offset_t offset1;
  } lane_offsets_t;

  // decode to execute record, one per beat
  typedef struct packed {
    valu_op_t      op;
    vreg_idx_t     vd;
    sew_t          eew;
    sew_t          vs2_sew;
    lane_offsets_t woffset;
    lane_offsets_t vs2_offset;
    logic [1:0]    wen;
    logic          decode_done;
  } exec_rec_t;

endpackage

`default_nettype wire

//--- hdl/vdec_decoder.sv
// vdec_decoder: combinational decode of a vector instruction word into
// op, register fields, width flags and offset sources
`timescale 1ns/1ns
`default_nettype none

module vdec_decoder (
  input  vdec_pkg::instr_t    instr,
  output vdec_pkg::dec_ctrl_t ctrl
);
  import vdec_pkg::*;

  // OP-V major opcode
  localparam logic [6:0] VOPCODE = 7'h57;

  // funct3 categories
  localparam logic [2:0] F3_OPIVV = 3'b000;
  localparam logic [2:0] F3_OPMVV = 3'b010;
  localparam logic [2:0] F3_OPIVI = 3'b011;
  localparam logic [2:0] F3_OPIVX = 3'b100;
  localparam logic [2:0] F3_OPMVX = 3'b110;

  // funct6 values
  localparam logic [5:0] F6_VADD     = 6'b000000;
  localparam logic [5:0] F6_VWADD    = 6'b110001;
  localparam logic [5:0] F6_VNSRL    = 6'b101100;
  localparam logic [5:0] F6_VSLIDEUP = 6'b001110;
  localparam logic [5:0] F6_VRGATHER = 6'b001100;

  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    vreg_idx_t  vs2;
    vreg_idx_t  vs1;
    logic [2:0] funct3;
    vreg_idx_t  vd;
    logic [6:0] opcode;
  } vfields_t;

  vfields_t f;
  valu_op_t op;

  assign f = vfields_t'(instr);

  always_comb begin
    op = OP_ILLEGAL;
    if (f.opcode == VOPCODE) begin
      case ({f.funct6, f.funct3})
        {F6_VADD, F3_OPIVV}:     op = OP_ADD;
        {F6_VWADD, F3_OPMVV}:    op = OP_WADD;
        {F6_VNSRL, F3_OPIVV}:    op = OP_NSRL;
        // slide1up and slideup.vx share funct6, funct3 tells them apart
        {F6_VSLIDEUP, F3_OPMVX}: op = OP_SLIDE1UP;
        {F6_VSLIDEUP, F3_OPIVX}: op = OP_SLIDEUP_X;
        {F6_VRGATHER, F3_OPIVI}: op = OP_GATHER_I;
        default:                 op = OP_ILLEGAL;
      endcase
    end
  end

  always_comb begin
    ctrl.op        = op;
    ctrl.vd        = f.vd;
    ctrl.vs1       = f.vs1;
    ctrl.vs2       = f.vs2;
    // imm5 lives in the vs1 slot
    ctrl.imm5      = f.vs1;
    ctrl.vm        = f.vm;
    ctrl.vd_widen  = (op == OP_WADD);
    ctrl.vd_narrow = (op == OP_NSRL);
    ctrl.legal     = (op != OP_ILLEGAL);

    ctrl.vd_src  = VD_SRC_NORMAL;
    ctrl.vs2_src = VS2_SRC_NORMAL;
    case (op)
      OP_SLIDE1UP:  ctrl.vd_src  = VD_SRC_IDX_PLUS_1;
      OP_SLIDEUP_X: ctrl.vd_src  = VD_SRC_IDX_PLUS_RS1;
      OP_GATHER_I:  ctrl.vs2_src = VS2_SRC_UIMM;
      default: begin
        ctrl.vd_src  = VD_SRC_NORMAL;
        ctrl.vs2_src = VS2_SRC_NORMAL;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/elem_sequencer.sv
// elem_sequencer: walks element offsets from vstart to vl, STEP per beat,
// and tracks busy across the beats of one instruction
`timescale 1ns/1ns
`default_nettype none

module elem_sequencer #(
  parameter int unsigned STEP = 2
) (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              start,
  input  logic              legal,
  input  vdec_pkg::offset_t vl,
  input  vdec_pkg::offset_t vstart,
  input  logic              stall,
  input  logic              flush,
  output vdec_pkg::offset_t offset,
  output logic              beat_valid,
  output logic              next_done,
  output logic              busy
);
  import vdec_pkg::*;

  // one extra bit so offset + STEP near the top does not wrap
  localparam int unsigned EXT_W = OFFSET_W + 1;

  offset_t          off_q;
  logic             start_ok;
  logic [EXT_W-1:0] next_off_ext;

  // beat 0 runs in the start cycle itself, straight from vstart
  assign offset = busy ? off_q : vstart;

  // empty ranges (vstart >= vl) never start
  assign start_ok = start && !busy && !stall && legal && (vstart < vl);

  assign beat_valid = start_ok || (busy && !stall);

  assign next_off_ext = {1'b0, offset} + EXT_W'(STEP);

  // current offset is the last one when the next would reach vl
  assign next_done = (next_off_ext >= {1'b0, vl});

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy  <= 1'b0;
      off_q <= '0;
    end else if (flush) begin
      busy  <= 1'b0;
      off_q <= '0;
    end else if (beat_valid) begin
      off_q <= next_off_ext[OFFSET_W-1:0];
      busy  <= !next_done;
    end
  end

endmodule

`default_nettype wire

//--- hdl/width_mask_unit.sv
// width_mask_unit: effective and vs2 element widths, plus the per-lane
// write enables after vl and mask checks
`timescale 1ns/1ns
`default_nettype none

module width_mask_unit (
  input  vdec_pkg::dec_ctrl_t ctrl,
  input  vdec_pkg::sew_t      vtype_sew,
  input  logic [1:0]          mask_bits,
  input  logic                beat_valid,
  input  vdec_pkg::offset_t   offset,
  input  vdec_pkg::offset_t   vl,
  output vdec_pkg::sew_t      eew,
  output vdec_pkg::sew_t      vs2_sew,
  output logic [1:0]          wen
);
  import vdec_pkg::*;

  localparam int unsigned EXT_W = OFFSET_W + 1;

  // one step wider, saturating at 32 bits
  function automatic sew_t sew_up(input sew_t s);
    case (s)
      SEW8:    return SEW16;
      default: return SEW32;
    endcase
  endfunction

  // one step narrower, saturating at 8 bits
  function automatic sew_t sew_down(input sew_t s);
    case (s)
      SEW32:   return SEW16;
      default: return SEW8;
    endcase
  endfunction

  always_comb begin
    if (ctrl.vd_widen) begin
      eew = sew_up(vtype_sew);
    end else if (ctrl.vd_narrow) begin
      eew = sew_down(vtype_sew);
    end else begin
      eew = vtype_sew;
    end
  end

  // narrowing reads a 2*SEW source
  assign vs2_sew = ctrl.vd_narrow ? sew_up(vtype_sew) : vtype_sew;

  // lane i sits at offset + i; tail lanes past vl are never written
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      wen[i] = beat_valid
               && (({1'b0, offset} + EXT_W'(i)) < {1'b0, vl})
               && (ctrl.vm || mask_bits[i]);
    end
  end

endmodule

`default_nettype wire

//--- hdl/decode_latch.sv
// decode_latch: forms destination and vs2 offset pairs and registers the
// execute record, with flush over stall
`timescale 1ns/1ns
`default_nettype none

module decode_latch (
  input  logic                CLK,
  input  logic                nRST,
  input  vdec_pkg::dec_ctrl_t ctrl,
  input  vdec_pkg::offset_t   offset,
  input  vdec_pkg::xlen_t     xs1,
  input  vdec_pkg::sew_t      eew,
  input  vdec_pkg::sew_t      vs2_sew,
  input  logic [1:0]          wen,
  input  logic                beat_valid,
  input  logic                next_done,
  input  logic                stall,
  input  logic                flush,
  output vdec_pkg::exec_rec_t rec
);
  import vdec_pkg::*;

  offset_t       xs1_off;
  offset_t       uimm_off;
  lane_offsets_t woff;
  lane_offsets_t vs2_off;
  exec_rec_t     rec_d;

  // slide amount only matters modulo the offset range
  assign xs1_off  = xs1[OFFSET_W-1:0];
  assign uimm_off = {{(OFFSET_W-5){1'b0}}, ctrl.imm5};

  // destination offsets
  always_comb begin
    case (ctrl.vd_src)
      VD_SRC_IDX_PLUS_1: begin
        woff.offset0 = offset + offset_t'(1);
        woff.offset1 = offset + offset_t'(2);
      end
      VD_SRC_IDX_PLUS_RS1: begin
        woff.offset0 = offset + xs1_off;
        woff.offset1 = offset + xs1_off + offset_t'(1);
      end
      default: begin
        woff.offset0 = offset;
        woff.offset1 = offset + offset_t'(1);
      end
    endcase
  end

  // vs2 offsets, gather by immediate reads one element for both lanes
  always_comb begin
    case (ctrl.vs2_src)
      VS2_SRC_UIMM: begin
        vs2_off.offset0 = uimm_off;
        vs2_off.offset1 = uimm_off;
      end
      default: begin
        vs2_off.offset0 = offset;
        vs2_off.offset1 = offset + offset_t'(1);
      end
    endcase
  end

  always_comb begin
    rec_d             = '0;
    rec_d.op          = ctrl.op;
    rec_d.vd          = ctrl.vd;
    rec_d.eew         = eew;
    rec_d.vs2_sew     = vs2_sew;
    rec_d.woffset     = woff;
    rec_d.vs2_offset  = vs2_off;
    rec_d.wen         = wen;
    rec_d.decode_done = beat_valid && next_done;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rec <= '0;
    end else if (flush) begin
      rec <= '0;
    end else if (!stall) begin
      rec <= rec_d;
    end
  end

endmodule

`default_nettype wire

//--- hdl/vector_decode_stage.sv
// vector_decode_stage: two-lane vector decode, from instruction word to
// the registered decode to execute record
`timescale 1ns/1ns
`default_nettype none

module vector_decode_stage #(
  parameter int unsigned LANES = 2
) (
  input  logic                CLK,
  input  logic                nRST,
  input  vdec_pkg::instr_t    instr,
  input  logic                start,
  input  vdec_pkg::sew_t      vtype_sew,
  input  vdec_pkg::offset_t   vl,
  input  vdec_pkg::offset_t   vstart,
  input  vdec_pkg::xlen_t     xs1,
  input  logic [1:0]          mask_bits,
  input  logic                stall,
  input  logic                flush,
  output vdec_pkg::exec_rec_t rec,
  output logic                busy
);
  import vdec_pkg::*;

  dec_ctrl_t  ctrl;
  offset_t    offset;
  logic       beat_valid;
  logic       next_done;
  sew_t       eew;
  sew_t       vs2_sew;
  logic [1:0] wen;

  vdec_decoder u_decoder (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // one beat covers LANES elements
  elem_sequencer #(
    .STEP (LANES)
  ) u_sequencer (
    .CLK        (CLK),
    .nRST       (nRST),
    .start      (start),
    .legal      (ctrl.legal),
    .vl         (vl),
    .vstart     (vstart),
    .stall      (stall),
    .flush      (flush),
    .offset     (offset),
    .beat_valid (beat_valid),
    .next_done  (next_done),
    .busy       (busy)
  );

  width_mask_unit u_width_mask (
    .ctrl       (ctrl),
    .vtype_sew  (vtype_sew),
    .mask_bits  (mask_bits),
    .beat_valid (beat_valid),
    .offset     (offset),
    .vl         (vl),
    .eew        (eew),
    .vs2_sew    (vs2_sew),
    .wen        (wen)
  );

  decode_latch u_latch (
    .CLK        (CLK),
    .nRST       (nRST),
    .ctrl       (ctrl),
    .offset     (offset),
    .xs1        (xs1),
    .eew        (eew),
    .vs2_sew    (vs2_sew),
    .wen        (wen),
    .beat_valid (beat_valid),
    .next_done  (next_done),
    .stall      (stall),
    .flush      (flush),
    .rec        (rec)
  );

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
// tb_clock: free-running testbench clock and a power-on reset that
// releases shortly after the last reset edge
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int unsigned PERIOD_NS    = 20,
  parameter int unsigned RESET_CYCLES = 4
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // release 2 ns after an edge, like every other input
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #2;
    nRST = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/vector_decode_stage_tb.sv
// Testbench for the two-lane vector decode stage
// random instruction sequences with stall and flush against a cycle model
`timescale 1ns/1ns
`default_nettype none

module vector_decode_stage_tb;
  import vdec_pkg::*;

  localparam int unsigned SEED      = 32'h127ed209;
  localparam int          NUM_SEQ   = 400;
  localparam int          MAX_VL    = 48;
  localparam int          MAX_BEATS = (MAX_VL + 1) / 2;
  // stalls stretch the beats and idle gaps add a few cycles per sequence
  localparam int          CYCLE_LIMIT = NUM_SEQ * (4 * MAX_BEATS + 8) + 20;

  // funct6 and funct3 of each legal op, in valu_op_t order
  localparam logic [8:0] OP_KEYS [0:5] = '{
    9'b000000_000, 9'b110001_010, 9'b101100_000,
    9'b001110_110, 9'b001110_100, 9'b001100_011
  };

  logic       CLK;
  logic       nRST;
  instr_t     instr;
  logic       start;
  sew_t       vtype_sew;
  offset_t    vl;
  offset_t    vstart;
  xlen_t      xs1;
  logic [1:0] mask_bits;
  logic       stall;
  logic       flush;
  exec_rec_t  rec;
  logic       busy;

  // model state, valid after the next rising edge
  logic      m_busy;
  offset_t   m_off;
  exec_rec_t m_rec;

  int cycle_count  = 0;
  int beat_count   = 0;
  int done_count   = 0;
  int flush_count  = 0;
  int ignore_count = 0;

  tb_clock #(
    .PERIOD_NS    (20),
    .RESET_CYCLES (4)
  ) u_clock (
    .CLK  (CLK),
    .nRST (nRST)
  );

  vector_decode_stage #(
    .LANES (2)
  ) u_vector_decode_stage (
    .CLK       (CLK),
    .nRST      (nRST),
    .instr     (instr),
    .start     (start),
    .vtype_sew (vtype_sew),
    .vl        (vl),
    .vstart    (vstart),
    .xs1       (xs1),
    .mask_bits (mask_bits),
    .stall     (stall),
    .flush     (flush),
    .rec       (rec),
    .busy      (busy)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_rec(input exec_rec_t got, input exec_rec_t exp, input string name);
    if (got !== exp) begin
      report_failure($sformatf("ERROR t=%0t %s got=%h expected=%h", $time, name, got, exp));
    end
  endtask

  task automatic check_sew(input sew_t got, input sew_t exp, input string name);
    if (got !== exp) begin
      report_failure($sformatf("ERROR t=%0t %s got=%0d expected=%0d", $time, name, got, exp));
    end
  endtask

  task automatic check_busy(input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR t=%0t busy got=%b expected=%b", $time, got, exp));
    end
  endtask

  function automatic logic chance(input int pct);
    return ($urandom_range(99) < pct);
  endfunction

  // sel 0..5 picks a legal op, 6 random funct fields, 7 a wrong opcode
  function automatic instr_t build_instr(input int sel);
    logic [8:0] key;
    logic [6:0] opc;
    key = (sel < 6) ? OP_KEYS[sel] : 9'($urandom);
    opc = (sel == 7) ? (7'h57 ^ 7'($urandom_range(127, 1))) : 7'h57;
    return {key[8:3], 1'($urandom), 5'($urandom), 5'($urandom), key[2:0],
            5'($urandom), opc};
  endfunction

  function automatic valu_op_t expected_op(input instr_t w);
    valu_op_t op;
    op = OP_ILLEGAL;
    if (w[6:0] == 7'h57) begin
      case ({w[31:26], w[14:12]})
        9'b000000_000: op = OP_ADD;
        9'b110001_010: op = OP_WADD;
        9'b101100_000: op = OP_NSRL;
        9'b001110_110: op = OP_SLIDE1UP;
        9'b001110_100: op = OP_SLIDEUP_X;
        9'b001100_011: op = OP_GATHER_I;
        default:       op = OP_ILLEGAL;
      endcase
    end
    return op;
  endfunction

  function automatic sew_t wider_sew(input sew_t s);
    return (s == SEW32) ? SEW32 : sew_t'(s + 2'd1);
  endfunction

  function automatic sew_t narrower_sew(input sew_t s);
    return (s == SEW8) ? SEW8 : sew_t'(s - 2'd1);
  endfunction

  // record the stage should latch for the current inputs at element cur
  function automatic exec_rec_t predict_rec(input int cur, input logic bv, input logic last);
    exec_rec_t r;
    valu_op_t  op;
    int        shift;
    op    = expected_op(instr);
    shift = int'(xs1[OFFSET_W-1:0]);
    r         = '0;
    r.op      = op;
    r.vd      = instr[11:7];
    r.eew     = vtype_sew;
    r.vs2_sew = vtype_sew;
    if (op == OP_WADD) begin
      r.eew = wider_sew(vtype_sew);
    end
    if (op == OP_NSRL) begin
      r.eew     = narrower_sew(vtype_sew);
      r.vs2_sew = wider_sew(vtype_sew);
    end
    r.woffset.offset0    = offset_t'(cur);
    r.woffset.offset1    = offset_t'(cur + 1);
    r.vs2_offset.offset0 = offset_t'(cur);
    r.vs2_offset.offset1 = offset_t'(cur + 1);
    case (op)
      OP_SLIDE1UP: begin
        r.woffset.offset0 = offset_t'(cur + 1);
        r.woffset.offset1 = offset_t'(cur + 2);
      end
      OP_SLIDEUP_X: begin
        r.woffset.offset0 = offset_t'(cur + shift);
        r.woffset.offset1 = offset_t'(cur + shift + 1);
      end
      OP_GATHER_I: begin
        r.vs2_offset.offset0 = offset_t'(instr[19:15]);
        r.vs2_offset.offset1 = offset_t'(instr[19:15]);
      end
      default: begin
      end
    endcase
    for (int i = 0; i < 2; i++) begin
      r.wen[i] = bv && ((cur + i) < int'(vl)) && (instr[25] || mask_bits[i]);
    end
    r.decode_done = bv && last;
    return r;
  endfunction

  // advance the model over one edge, then compare after the edge
  task automatic step_cycle();
    int        cur;
    logic      legal;
    logic      bv;
    logic      last;
    exec_rec_t next_rec;
    cur      = m_busy ? int'(m_off) : int'(vstart);
    legal    = (expected_op(instr) != OP_ILLEGAL);
    bv       = (m_busy && !stall) || (start && !m_busy && !stall && legal && (vstart < vl));
    last     = (cur + 2) >= int'(vl);
    next_rec = predict_rec(cur, bv, last);
    if (start && !m_busy && !bv) begin
      ignore_count++;
    end
    if (flush) begin
      m_busy = 1'b0;
      m_off  = '0;
      m_rec  = '0;
      flush_count++;
    end else begin
      if (!stall) begin
        m_rec = next_rec;
      end
      if (bv) begin
        m_off  = offset_t'(cur + 2);
        m_busy = !last;
        beat_count++;
        if (last) begin
          done_count++;
        end
      end
    end
    @(posedge CLK);
    #2;
    check_busy(busy, m_busy);
    check_sew(rec.eew, m_rec.eew, "rec.eew");
    check_sew(rec.vs2_sew, m_rec.vs2_sew, "rec.vs2_sew");
    check_rec(rec, m_rec, "rec");
  endtask

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      report_failure($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  initial begin
    int sel;
    int gap;
    void'($urandom(SEED));
    instr     = '0;
    start     = 1'b0;
    vtype_sew = SEW8;
    vl        = '0;
    vstart    = '0;
    xs1       = '0;
    mask_bits = '0;
    stall     = 1'b0;
    flush     = 1'b0;
    m_busy    = 1'b0;
    m_off     = '0;
    m_rec     = '0;

    wait (nRST === 1'b1);
    check_busy(busy, 1'b0);
    check_rec(rec, '0, "rec after reset");

    for (int s = 0; s < NUM_SEQ; s++) begin
      // mostly legal ops with some illegal encodings
      sel       = chance(80) ? int'($urandom_range(5)) : 6 + int'($urandom_range(1));
      instr     = build_instr(sel);
      vtype_sew = sew_t'($urandom_range(2));
      vl        = offset_t'($urandom_range(MAX_VL));
      vstart    = chance(15) ? offset_t'($urandom_range(MAX_VL + 4))
                             : offset_t'($urandom_range(int'(vl)));
      xs1       = $urandom();
      start     = 1'b1;
      stall     = chance(10);
      flush     = chance(3);
      mask_bits = 2'($urandom);
      step_cycle();

      while (busy) begin
        // start while busy must be ignored
        start     = chance(20);
        stall     = chance(25);
        flush     = chance(3);
        mask_bits = 2'($urandom);
        step_cycle();
      end

      gap = int'($urandom_range(2));
      repeat (gap) begin
        start     = 1'b0;
        stall     = chance(25);
        flush     = chance(5);
        mask_bits = 2'($urandom);
        step_cycle();
      end
    end

    $display("sequences %0d beats %0d completed %0d flushes %0d ignored starts %0d",
             NUM_SEQ, beat_count, done_count, flush_count, ignore_count);
    if (done_count > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("no sequence ran to its last beat");
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
hdl/vdec_pkg.sv
hdl/vdec_decoder.sv
hdl/elem_sequencer.sv
hdl/width_mask_unit.sv
hdl/decode_latch.sv
hdl/vector_decode_stage.sv
tb/tb_clock.sv
tb/vector_decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the decode stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
  --top-module vector_decode_stage_tb \
  -f sim.f \
  -o vector_decode_stage_sim

./obj_dir/vector_decode_stage_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "simulation FAILED"
  exit 1
fi

if ! grep -q "Test completed successfully" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
